// File: design/rv_decode_exec.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_decode_exec (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [31:0]         instr,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic                instr_valid,
    input  logic                stall,
    output rv_pipe_pkg::wb_t    wb,
    output logic                redirect,
    output logic [`RV_XLEN-1:0] redirect_pc
);

    rv_pipe_pkg::id_ctrl_t ctrl_id;
    rv_pipe_pkg::id_ctrl_t ctrl_ex;
    rv_pipe_pkg::id_data_t data_id;
    rv_pipe_pkg::id_data_t data_ex;
    logic [31:0]           imm;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;

    rv_decoder decoder_inst (
        .instr       (instr),
        .instr_valid (instr_valid),
        .ctrl        (ctrl_id),
        .imm         (imm)
    );

    // Write port comes straight from EX, giving the forwarding path
    rv_regfile regfile_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (instr[19:15]),
        .rs2      (instr[24:20]),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    // ID stage payload
    assign data_id.rd       = instr[11:7];
    assign data_id.rs1      = instr[19:15];
    assign data_id.rs2      = instr[24:20];
    assign data_id.rs1_data = rs1_data;
    assign data_id.rs2_data = rs2_data;
    assign data_id.imm      = imm;
    assign data_id.pc       = pc;
    assign data_id.pc_plus4 = pc + `RV_XLEN'(4);

    rv_reg_id_ex #(
        .PIPELINED (1)
    ) reg_id_ex_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall   (stall),
        .flush   (redirect),
        .ctrl_id (ctrl_id),
        .data_id (data_id),
        .ctrl_ex (ctrl_ex),
        .data_ex (data_ex)
    );

    rv_execute execute_inst (
        .ctrl        (ctrl_ex),
        .data        (data_ex),
        .wb          (wb),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

endmodule

`default_nettype wire

// File: design/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_decoder (
    input  logic [31:0]           instr,
    input  logic                  instr_valid,
    output rv_pipe_pkg::id_ctrl_t ctrl,
    output logic [31:0]           imm
);

    logic [31:0] iw;
    logic [2:0]  funct3;
    logic        funct7_b5;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    // An empty slot decodes as the canonical no-op
    assign iw        = instr_valid ? instr : `RV_NOP;
    assign funct3    = iw[14:12];
    assign funct7_b5 = iw[30];

    assign imm_i = {{20{iw[31]}}, iw[31:20]};
    assign imm_b = {{19{iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};
    assign imm_u = {iw[31:12], 12'b0};
    assign imm_j = {{11{iw[31]}}, iw[31], iw[19:12], iw[20], iw[30:21], 1'b0};

    // SUB only exists on OP; SRA/SRAI use funct7 bit 5 on both
    function automatic rv_isa_pkg::alu_op_e alu_from_funct(input logic [2:0] f3,
                                                          input logic is_op,
                                                          input logic f7b5);
        case (f3)
            3'b000:  return (is_op && f7b5) ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
            3'b001:  return rv_isa_pkg::ALU_SLL;
            3'b010:  return rv_isa_pkg::ALU_SLT;
            3'b011:  return rv_isa_pkg::ALU_SLTU;
            3'b100:  return rv_isa_pkg::ALU_XOR;
            3'b101:  return f7b5 ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            3'b110:  return rv_isa_pkg::ALU_OR;
            default: return rv_isa_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl = rv_pipe_pkg::CTRL_BUBBLE;
        imm  = imm_i;
        case (rv_isa_pkg::opcode_e'(iw[6:0]))
            rv_isa_pkg::OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_from_funct(funct3, 1'b1, funct7_b5);
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_b_imm = 1'b1;
                ctrl.alu_op    = alu_from_funct(funct3, 1'b0, funct7_b5);
            end
            rv_isa_pkg::OPC_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_a_sel = rv_isa_pkg::A_ZERO;
                ctrl.alu_b_imm = 1'b1;
                imm            = imm_u;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_a_sel = rv_isa_pkg::A_PC;
                ctrl.alu_b_imm = 1'b1;
                imm            = imm_u;
            end
            rv_isa_pkg::OPC_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_a_sel = rv_isa_pkg::A_PC;
                ctrl.alu_b_imm = 1'b1;
                ctrl.is_jump   = 1'b1;
                imm            = imm_j;
            end
            rv_isa_pkg::OPC_JALR: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_a_sel = rv_isa_pkg::A_PC;
                ctrl.alu_b_imm = 1'b1;
                ctrl.is_jump   = 1'b1;
                ctrl.jalr      = 1'b1;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                imm = imm_b;
                // funct3 010 and 011 are reserved and stay a bubble
                if (funct3[2:1] != 2'b01) begin
                    ctrl.is_branch = 1'b1;
                    ctrl.br_cond   = rv_isa_pkg::br_cond_e'(funct3);
                end
            end
            default: ;
        endcase

        if (iw == `RV_NOP) begin
            ctrl = rv_pipe_pkg::CTRL_BUBBLE;
        end
    end

endmodule

`default_nettype wire

// File: design/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Integer data path width
`define RV_XLEN 32

// Architectural register count, x0 included
`define RV_NREGS 32

// Canonical no-op: addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

// File: design/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_execute (
    input  rv_pipe_pkg::id_ctrl_t ctrl,
    input  rv_pipe_pkg::id_data_t data,
    output rv_pipe_pkg::wb_t      wb,
    output logic                  redirect,
    output logic [`RV_XLEN-1:0]   redirect_pc
);

    localparam int SHW = $clog2(`RV_XLEN);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_res;
    logic [`RV_XLEN-1:0] jb_base;
    logic [`RV_XLEN-1:0] jb_sum;
    logic                rs_eq;
    logic                rs_lt_s;
    logic                rs_lt_u;
    logic                br_taken;

    // Operand select
    always_comb begin
        case (ctrl.alu_a_sel)
            rv_isa_pkg::A_RS1: op_a = data.rs1_data;
            rv_isa_pkg::A_PC:  op_a = data.pc;
            default:           op_a = '0;
        endcase
    end

    assign op_b = ctrl.alu_b_imm ? data.imm : data.rs2_data;

    always_comb begin
        case (ctrl.alu_op)
            rv_isa_pkg::ALU_ADD:    alu_res = op_a + op_b;
            rv_isa_pkg::ALU_SUB:    alu_res = op_a - op_b;
            rv_isa_pkg::ALU_SLL:    alu_res = op_a << op_b[SHW-1:0];
            rv_isa_pkg::ALU_SLT:    alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_isa_pkg::ALU_SLTU:   alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            rv_isa_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
            rv_isa_pkg::ALU_SRL:    alu_res = op_a >> op_b[SHW-1:0];
            rv_isa_pkg::ALU_SRA:    alu_res = $signed(op_a) >>> op_b[SHW-1:0];
            rv_isa_pkg::ALU_OR:     alu_res = op_a | op_b;
            rv_isa_pkg::ALU_AND:    alu_res = op_a & op_b;
            rv_isa_pkg::ALU_PASS_B: alu_res = op_b;
            default:                alu_res = '0;
        endcase
    end

    // Branch comparison on the raw register operands
    assign rs_eq   = data.rs1_data == data.rs2_data;
    assign rs_lt_s = $signed(data.rs1_data) < $signed(data.rs2_data);
    assign rs_lt_u = data.rs1_data < data.rs2_data;

    always_comb begin
        case (ctrl.br_cond)
            rv_isa_pkg::BR_BEQ:  br_taken = rs_eq;
            rv_isa_pkg::BR_BNE:  br_taken = !rs_eq;
            rv_isa_pkg::BR_BLT:  br_taken = rs_lt_s;
            rv_isa_pkg::BR_BGE:  br_taken = !rs_lt_s;
            rv_isa_pkg::BR_BLTU: br_taken = rs_lt_u;
            rv_isa_pkg::BR_BGEU: br_taken = !rs_lt_u;
            default:             br_taken = 1'b0;
        endcase
    end

    // JALR targets rs1 plus imm with bit 0 dropped
    assign jb_base     = ctrl.jalr ? data.rs1_data : data.pc;
    assign jb_sum      = jb_base + data.imm;
    assign redirect_pc = {jb_sum[`RV_XLEN-1:1], jb_sum[0] & !ctrl.jalr};
    assign redirect    = ctrl.is_jump || (ctrl.is_branch && br_taken);

    assign wb.en   = ctrl.reg_write && (data.rd != 5'd0);
    assign wb.rd   = data.rd;
    assign wb.data = ctrl.is_jump ? data.pc_plus4 : alu_res;

endmodule

`default_nettype wire

// File: design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Major opcodes handled by this slice
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // Values match the branch funct3 field
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } br_cond_e;

    typedef enum logic [1:0] {
        A_RS1  = 2'd0,
        A_PC   = 2'd1,
        A_ZERO = 2'd2
    } alu_a_sel_e;

endpackage

`default_nettype wire

// File: design/rv_pipe_pkg.sv
`default_nettype none

`include "rv_defs.svh"

package rv_pipe_pkg;

    // Decoded control for one instruction
    typedef struct packed {
        logic                   reg_write;
        rv_isa_pkg::alu_a_sel_e alu_a_sel;
        logic                   alu_b_imm;
        rv_isa_pkg::alu_op_e    alu_op;
        logic                   is_branch;
        logic                   is_jump;
        logic                   jalr;
        rv_isa_pkg::br_cond_e   br_cond;
    } id_ctrl_t;

    // Operands and addresses carried from ID into EX
    typedef struct packed {
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [`RV_XLEN-1:0] rs1_data;
        logic [`RV_XLEN-1:0] rs2_data;
        logic [`RV_XLEN-1:0] imm;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] pc_plus4;
    } id_data_t;

    // Register file write port
    typedef struct packed {
        logic                en;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] data;
    } wb_t;

    // Control word with no architectural effect
    localparam id_ctrl_t CTRL_BUBBLE = '{
        reg_write: 1'b0,
        alu_a_sel: rv_isa_pkg::A_RS1,
        alu_b_imm: 1'b0,
        alu_op:    rv_isa_pkg::ALU_ADD,
        is_branch: 1'b0,
        is_jump:   1'b0,
        jalr:      1'b0,
        br_cond:   rv_isa_pkg::BR_BEQ
    };

endpackage

`default_nettype wire

// File: design/rv_reg_id_ex.sv
`timescale 1ns/1ps
`default_nettype none

module rv_reg_id_ex #(
    parameter int PIPELINED = 1
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // Hazard control
    input  logic                  stall,
    input  logic                  flush,

    // Decode side
    input  rv_pipe_pkg::id_ctrl_t ctrl_id,
    input  rv_pipe_pkg::id_data_t data_id,

    // Execute side
    output rv_pipe_pkg::id_ctrl_t ctrl_ex,
    output rv_pipe_pkg::id_data_t data_ex
);

    if (PIPELINED != 0) begin : g_registered

        // Flush beats stall so a redirect always squashes the slot
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                ctrl_ex <= rv_pipe_pkg::CTRL_BUBBLE;
            end else if (flush) begin
                ctrl_ex <= rv_pipe_pkg::CTRL_BUBBLE;
            end else if (!stall) begin
                ctrl_ex <= ctrl_id;
            end
        end

        // Operand payload follows ID unless stalled
        always_ff @(posedge clk) begin
            if (!stall) begin
                data_ex <= data_id;
            end
        end

    end else begin : g_passthrough

        assign ctrl_ex = ctrl_id;
        assign data_ex = data_id;

    end

endmodule

`default_nettype wire

// File: design/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data,
    input  rv_pipe_pkg::wb_t    wb
);

    // x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];
    logic                wr_active;

    assign wr_active = wb.en && (wb.rd != 5'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_active) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Same-cycle write wins, which carries the EX result back into ID
    function automatic logic [`RV_XLEN-1:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end
        if (wr_active && (wb.rd == addr)) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only on the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module rv_decode_exec_tb \
    -f rv_decode_exec.f -o rv_decode_exec_sim || exit 1

out=$(./obj_dir/rv_decode_exec_sim)
echo "$out"
echo "$out" | grep -qx "ALL CHECKS PASSED" && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

// File: rv_decode_exec.f
+incdir+design
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_reg_id_ex.sv
design/rv_execute.sv
design/rv_decode_exec.sv
test/rv_decode_exec_tb.sv

// File: test/rv_decode_exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode_exec_tb;

    // Architectural outcome of one instruction in EX
    typedef struct packed {
        logic        en;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        redir;
        logic [31:0] rpc;
    } exec_t;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic        valid;
        logic        stall;
        exec_t       exp;
        logic [3:0]  test;
    } row_t;

    logic             clk;
    logic             rst_n;
    logic [31:0]      instr;
    logic [31:0]      pc;
    logic             instr_valid;
    logic             stall;
    rv_pipe_pkg::wb_t wb;
    logic             redirect;
    logic [31:0]      redirect_pc;

    row_t        rows [0:255];
    int          n_rows = 0;
    logic        built = 1'b0;
    logic [31:0] ref_regs [0:31];
    exec_t       ex_state;
    logic [31:0] cur_pc;
    logic [31:0] lcg_state = 32'd37265;
    int          errors = 0;
    int          test_errors = 0;

    rv_decode_exec rv_decode_exec_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .pc          (pc),
        .instr_valid (instr_valid),
        .stall       (stall),
        .wb          (wb),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                            input logic arith, input logic [31:0] a,
                                            input logic [31:0] b);
        case (f3)
            3'd0: return sub ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (arith) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // RV32I semantics for the supported subset
    function automatic exec_t exec_ref(input logic [31:0] iw, input logic [31:0] ipc,
                                       input logic valid);
        exec_t       r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ii;
        logic [2:0]  f3;
        logic        tk;
        r  = '0;
        a  = ref_regs[iw[19:15]];
        b  = ref_regs[iw[24:20]];
        ii = {{20{iw[31]}}, iw[31:20]};
        f3 = iw[14:12];
        tk = 1'b0;
        if (!valid) begin
            return r;
        end
        r.rd = iw[11:7];
        case (iw[6:0])
            7'h33: begin
                r.en   = 1'b1;
                r.data = alu_ref(f3, iw[30], iw[30], a, b);
            end
            7'h13: begin
                r.en   = 1'b1;
                r.data = alu_ref(f3, 1'b0, iw[30], a, ii);
            end
            7'h37: begin
                r.en   = 1'b1;
                r.data = {iw[31:12], 12'b0};
            end
            7'h17: begin
                r.en   = 1'b1;
                r.data = ipc + {iw[31:12], 12'b0};
            end
            7'h6f: begin
                r.en    = 1'b1;
                r.data  = ipc + 32'd4;
                r.redir = 1'b1;
                r.rpc   = ipc + {{11{iw[31]}}, iw[31], iw[19:12], iw[20], iw[30:21], 1'b0};
            end
            7'h67: begin
                r.en    = 1'b1;
                r.data  = ipc + 32'd4;
                r.redir = 1'b1;
                r.rpc   = (a + ii) & ~32'd1;
            end
            7'h63: begin
                case (f3)
                    3'b000: tk = a == b;
                    3'b001: tk = a != b;
                    3'b100: tk = $signed(a) < $signed(b);
                    3'b101: tk = $signed(a) >= $signed(b);
                    3'b110: tk = a < b;
                    3'b111: tk = a >= b;
                    default: tk = 1'b0;
                endcase
                r.redir = tk;
                r.rpc   = ipc + {{19{iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};
            end
            default: ;
        endcase
        r.en = r.en && (r.rd != 5'd0);
        return r;
    endfunction

    // Steps the pipeline model by one cycle and records the expected EX state
    task automatic add_row(input logic [31:0] iw, input logic valid, input logic stl,
                           input logic [3:0] test);
        if (ex_state.en) begin
            ref_regs[ex_state.rd] = ex_state.data;
        end
        rows[n_rows].instr = iw;
        rows[n_rows].pc    = cur_pc;
        rows[n_rows].valid = valid;
        rows[n_rows].stall = stl;
        rows[n_rows].test  = test;
        if (ex_state.redir) begin
            ex_state = '0;
        end else if (!stl) begin
            ex_state = exec_ref(iw, cur_pc, valid);
        end
        rows[n_rows].exp = ex_state;
        n_rows++;
        if (!stl) begin
            cur_pc = cur_pc + 32'd4;
        end
    endtask

    task automatic load_reg(input logic [4:0] rd, input logic [31:0] value, input logic [3:0] t);
        logic [19:0] hi;
        hi = value[31:12] + {19'b0, value[11]};
        add_row({hi, rd, 7'b0110111}, 1'b1, 1'b0, t);
        add_row(enc_i(value[11:0], rd, 3'd0, rd, 7'h13), 1'b1, 1'b0, t);
    endtask

    task automatic build_table();
        logic [11:0] imm;
        logic [31:0] filler;
        filler   = enc_r(7'd0, 5'd8, 5'd8, 3'd0, 5'd10);
        ex_state = '0;
        cur_pc   = 32'h0000_1000;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        for (int r = 0; r < 32; r++) begin
            add_row(enc_r(7'd0, 5'd0, 5'(r), 3'd0, 5'(r)), 1'b1, 1'b0, 4'd1);
        end
        load_reg(5'd1, lcg_next(), 4'd2);
        load_reg(5'd2, lcg_next(), 4'd2);
        for (int f = 0; f < 8; f++) begin
            imm = 12'(lcg_next() >> 7);
            if (f == 1 || f == 5) begin
                imm = {1'b0, (f == 5) ? imm[10] : 1'b0, 5'b0, imm[4:0]};
            end
            add_row(enc_i(imm, 5'd1, 3'(f), 5'(10 + f), 7'h13), 1'b1, 1'b0, 4'd2);
        end
        for (int k = 0; k < 10; k++) begin
            add_row(enc_r((k >= 8) ? 7'h20 : 7'h00, 5'd2, 5'd1,
                          (k == 8) ? 3'd0 : (k == 9) ? 3'd5 : 3'(k), 5'(20 + k)),
                    1'b1, 1'b0, 4'd2);
        end
        add_row(enc_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd0), 1'b1, 1'b0, 4'd2);
        add_row(enc_i(12'd7, 5'd0, 3'd0, 5'd5, 7'h13), 1'b1, 1'b0, 4'd3);
        add_row(enc_i(12'd3, 5'd5, 3'd0, 5'd6, 7'h13), 1'b1, 1'b0, 4'd3);
        add_row(enc_r(7'd0, 5'd5, 5'd6, 3'd0, 5'd7), 1'b1, 1'b0, 4'd3);
        add_row(enc_i(12'd5, 5'd0, 3'd0, 5'd8, 7'h13), 1'b1, 1'b0, 4'd4);
        add_row(enc_i(12'hffd, 5'd0, 3'd0, 5'd9, 7'h13), 1'b1, 1'b0, 4'd4);
        // Taken forms, each followed by an instruction that gets squashed
        add_row(enc_b(13'd16, 5'd8, 5'd8, 3'b000), 1'b1, 1'b0, 4'd4);
        add_row(filler, 1'b1, 1'b0, 4'd4);
        add_row(enc_b(-13'sd8, 5'd9, 5'd8, 3'b001), 1'b1, 1'b0, 4'd4);
        add_row(filler, 1'b1, 1'b0, 4'd4);
        add_row(enc_b(13'd40, 5'd8, 5'd9, 3'b100), 1'b1, 1'b0, 4'd4);
        add_row(filler, 1'b1, 1'b0, 4'd4);
        add_row(enc_b(13'd20, 5'd9, 5'd8, 3'b101), 1'b1, 1'b0, 4'd4);
        add_row(filler, 1'b1, 1'b0, 4'd4);
        add_row(enc_b(13'd100, 5'd9, 5'd8, 3'b110), 1'b1, 1'b0, 4'd4);
        add_row(filler, 1'b1, 1'b0, 4'd4);
        add_row(enc_b(-13'sd64, 5'd8, 5'd9, 3'b111), 1'b1, 1'b0, 4'd4);
        add_row(filler, 1'b1, 1'b0, 4'd4);
        add_row(enc_j(21'd2048, 5'd1), 1'b1, 1'b0, 4'd4);
        add_row(filler, 1'b1, 1'b0, 4'd4);
        add_row(enc_i(12'd12, 5'd8, 3'd0, 5'd2, 7'h67), 1'b1, 1'b0, 4'd4);
        add_row(filler, 1'b1, 1'b0, 4'd4);
        // Not-taken branch leaves the next instruction to write
        add_row(enc_b(13'd16, 5'd9, 5'd8, 3'b000), 1'b1, 1'b0, 4'd4);
        add_row(filler, 1'b1, 1'b0, 4'd4);
        add_row(enc_i(12'd42, 5'd0, 3'd0, 5'd11, 7'h13), 1'b1, 1'b0, 4'd5);
        for (int s = 0; s < 3; s++) begin
            add_row(enc_i(12'd1, 5'd11, 3'd0, 5'd12, 7'h13), 1'b1, 1'b1, 4'd5);
        end
        add_row(enc_i(12'd1, 5'd11, 3'd0, 5'd12, 7'h13), 1'b1, 1'b0, 4'd5);
        add_row(enc_r(7'd0, 5'd11, 5'd12, 3'd0, 5'd13), 1'b1, 1'b0, 4'd5);
        for (int v = 0; v < 3; v++) begin
            add_row(enc_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd14), 1'b0, 1'b0, 4'd6);
        end
        add_row(enc_j(21'd16, 5'd3), 1'b0, 1'b0, 4'd6);
    endtask

    // EX must still be empty in the first cycle after reset release
    task automatic check_after_reset();
        if (wb.en !== 1'b0) begin
            $display("ERR reset wb.en exp %h got %h", 1'b0, wb.en);
            test_errors++;
        end
        if (redirect !== 1'b0) begin
            $display("ERR reset redirect exp %h got %h", 1'b0, redirect);
            test_errors++;
        end
    endtask

    task automatic check_row(input int i);
        exec_t e;
        e = rows[i].exp;
        if (wb.en !== e.en) begin
            $display("ERR row %0d wb.en exp %h got %h", i, e.en, wb.en);
            test_errors++;
        end
        if (e.en && (wb.rd !== e.rd)) begin
            $display("ERR row %0d wb.rd exp %h got %h", i, e.rd, wb.rd);
            test_errors++;
        end
        if (e.en && (wb.data !== e.data)) begin
            $display("ERR row %0d wb.data exp %h got %h", i, e.data, wb.data);
            test_errors++;
        end
        if (redirect !== e.redir) begin
            $display("ERR row %0d redirect exp %h got %h", i, e.redir, redirect);
            test_errors++;
        end
        if (e.redir && (redirect_pc !== e.rpc)) begin
            $display("ERR row %0d redirect_pc exp %h got %h", i, e.rpc, redirect_pc);
            test_errors++;
        end
        if (i == n_rows - 1 || rows[i + 1].test != rows[i].test) begin
            $display("test %0d finished with %0d errors", rows[i].test, test_errors);
            errors      = errors + test_errors;
            test_errors = 0;
        end
    endtask

    initial begin
        wait (built);
        #((n_rows + 20) * 4);
        $display("timeout: the run did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        // Jump waits in ID for the whole reset
        instr       = enc_j(21'd64, 5'd1);
        pc          = '0;
        instr_valid = 1'b1;
        stall       = 1'b0;
        build_table();
        built = 1'b1;
        repeat (5) @(posedge clk);
        rst_n       <= 1'b1;
        instr       <= 32'h0000_0013;
        instr_valid <= 1'b0;
        @(negedge clk);
        check_after_reset();
        for (int i = 0; i <= n_rows; i++) begin
            @(posedge clk);
            if (i < n_rows) begin
                instr       <= rows[i].instr;
                pc          <= rows[i].pc;
                instr_valid <= rows[i].valid;
                stall       <= rows[i].stall;
            end else begin
                instr_valid <= 1'b0;
                stall       <= 1'b0;
            end
            if (i > 0) begin
                @(negedge clk);
                check_row(i - 1);
            end
        end
        $display("rows %0d, errors %0d", n_rows, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
